//--- feat_front.f
logic/feat_front_pkg.sv
logic/feat_regfile.sv
logic/octave_sequencer.sv
logic/feat_front_top.sv
test/tb_clock_gen.sv
test/tb_feat_front.sv

//--- logic/feat_front_pkg.sv
`default_nettype none

package feat_front_pkg;

   localparam int num_ports = 2;
   localparam int reg_index_width = 5;

   localparam logic [31:0] byte_mask = 32'h0000_00ff;
   localparam logic [31:0] half_mask = 32'h0000_ffff;

   localparam logic [15:0] config0_rst = 16'h234;
   localparam logic [23:0] config1_rst = 24'hfff;
   localparam logic [7:0]  config2_rst = 8'h55;

   // Word index taken from paddr[6:2]
   typedef enum logic [reg_index_width-1:0] {
      reg_enables         = 5'd0,
      reg_control_stream1 = 5'd1,
      reg_control_stream2 = 5'd2,
      reg_input_select    = 5'd3,
      reg_config0         = 5'd4,
      reg_config1         = 5'd5,
      reg_config2         = 5'd6,
      reg_port0           = 5'd7,
      reg_port1           = 5'd8
   } reg_index_e;

   typedef enum logic [1:0] {
      size_word = 2'd0,
      size_byte = 2'd1,
      size_half = 2'd2
   } access_size_e;

   typedef struct packed {
      logic       lens_invariant;
      logic [5:0] pattern_scale;
      logic [2:0] num_octaves;
   } port_cfg_t;

   typedef struct packed {
      logic [31:0] enables;
      logic [31:0] control_stream1;
      logic [31:0] control_stream2;
      logic [31:0] input_select;
      logic [15:0] config0;
      logic [23:0] config1;
      logic [7:0]  config2;
   } ctrl_regs_t;

   typedef struct packed {
      logic [2:0]  octave;
      logic [11:0] scale;
      logic        lens_invariant;
   } octave_cmd_t;

   localparam ctrl_regs_t ctrl_regs_rst = '{
      enables:         32'h0,
      control_stream1: 32'h0,
      control_stream2: 32'h0,
      input_select:    32'h0,
      config0:         config0_rst,
      config1:         config1_rst,
      config2:         config2_rst
   };

   localparam port_cfg_t port_cfg_rst = '0;

endpackage

`default_nettype wire

//--- logic/feat_front_top.sv
`default_nettype none
`timescale 1ns/10ps

module feat_front_top
   import feat_front_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 psel,
   input  logic                 pwrite,
   input  access_size_e         psize,
   input  logic [6:0]           paddr,
   input  logic [31:0]          pwdata,
   input  logic [num_ports-1:0] frame_start,
   output logic [31:0]          prdata,
   output ctrl_regs_t           regs,
   output logic [num_ports-1:0] octave_valid,
   output octave_cmd_t          octave_cmd0,
   output octave_cmd_t          octave_cmd1,
   output logic [num_ports-1:0] done,
   output logic [num_ports-1:0] busy
);

   port_cfg_t port_cfg0;
   port_cfg_t port_cfg1;

   feat_regfile i_feat_regfile (
      .clk       (clk),
      .rst_n     (rst_n),
      .psel      (psel),
      .pwrite    (pwrite),
      .psize     (psize),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .regs      (regs),
      .port_cfg0 (port_cfg0),
      .port_cfg1 (port_cfg1)
   );

   octave_sequencer i_octave_sequencer0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (regs.enables[0]),
      .frame_start  (frame_start[0]),
      .cfg          (port_cfg0),
      .octave_valid (octave_valid[0]),
      .octave_cmd   (octave_cmd0),
      .done         (done[0]),
      .busy         (busy[0])
   );

   octave_sequencer i_octave_sequencer1 (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (regs.enables[1]),
      .frame_start  (frame_start[1]),
      .cfg          (port_cfg1),
      .octave_valid (octave_valid[1]),
      .octave_cmd   (octave_cmd1),
      .done         (done[1]),
      .busy         (busy[1])
   );

endmodule

`default_nettype wire

//--- logic/feat_regfile.sv
`default_nettype none
`timescale 1ns/10ps

module feat_regfile
   import feat_front_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         psel,
   input  logic         pwrite,
   input  access_size_e psize,
   input  logic [6:0]   paddr,
   input  logic [31:0]  pwdata,
   output logic [31:0]  prdata,
   output ctrl_regs_t   regs,
   output port_cfg_t    port_cfg0,
   output port_cfg_t    port_cfg1
);

   ctrl_regs_t  regs_q;
   port_cfg_t   port0_q;
   port_cfg_t   port1_q;
   reg_index_e  index;
   logic        wr_en;
   logic [31:0] wr_mask;
   logic [31:0] wr_data;
   logic [31:0] rd_data;

   // Replace the masked bits of the old value with the lane data
   function automatic logic [31:0] merge(input logic [31:0] old_val,
                                         input logic [31:0] mask,
                                         input logic [31:0] data);
      return (old_val & ~mask) | (data & mask);
   endfunction

   assign index = reg_index_e'(paddr[6:2]);
   assign wr_en = psel && pwrite;

   // Sub-word writes always land in the low lane
   always_comb begin
      case (psize)
         size_byte: begin
            wr_mask = byte_mask;
            wr_data = {4{pwdata[7:0]}};
         end
         size_half: begin
            wr_mask = half_mask;
            wr_data = {2{pwdata[15:0]}};
         end
         default: begin
            wr_mask = '1;
            wr_data = pwdata;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         regs_q  <= ctrl_regs_rst;
         port0_q <= port_cfg_rst;
         port1_q <= port_cfg_rst;
      end else if (wr_en) begin
         case (index)
            reg_enables:
               regs_q.enables <= merge(regs_q.enables, wr_mask, wr_data);
            reg_control_stream1:
               regs_q.control_stream1 <= merge(regs_q.control_stream1, wr_mask, wr_data);
            reg_control_stream2:
               regs_q.control_stream2 <= merge(regs_q.control_stream2, wr_mask, wr_data);
            reg_input_select:
               regs_q.input_select <= merge(regs_q.input_select, wr_mask, wr_data);
            reg_config0:
               regs_q.config0 <= 16'(merge(32'(regs_q.config0), wr_mask, wr_data));
            reg_config1:
               regs_q.config1 <= 24'(merge(32'(regs_q.config1), wr_mask, wr_data));
            reg_config2:
               regs_q.config2 <= 8'(merge(32'(regs_q.config2), wr_mask, wr_data));
            reg_port0:
               port0_q <= port_cfg_t'(10'(merge(32'(port0_q), wr_mask, wr_data)));
            reg_port1:
               port1_q <= port_cfg_t'(10'(merge(32'(port1_q), wr_mask, wr_data)));
            default: ; // Unmapped words drop the write
         endcase
      end
   end

   always_comb begin
      case (index)
         reg_enables:         rd_data = regs_q.enables;
         reg_control_stream1: rd_data = regs_q.control_stream1;
         reg_control_stream2: rd_data = regs_q.control_stream2;
         reg_input_select:    rd_data = regs_q.input_select;
         reg_config0:         rd_data = 32'(regs_q.config0);
         reg_config1:         rd_data = 32'(regs_q.config1);
         reg_config2:         rd_data = 32'(regs_q.config2);
         reg_port0:           rd_data = 32'(port0_q);
         reg_port1:           rd_data = 32'(port1_q);
         default:             rd_data = '0;
      endcase
   end

   // Read data follows paddr regardless of psel
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prdata <= '0;
      end else begin
         prdata <= rd_data;
      end
   end

   assign regs      = regs_q;
   assign port_cfg0 = port0_q;
   assign port_cfg1 = port1_q;

   a_legal_size: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> (psize != 2'd3))
      else $error("[ERROR] write with illegal psize 3 at paddr %h", paddr);

endmodule

`default_nettype wire

//--- logic/octave_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

module octave_sequencer
   import feat_front_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        enable,
   input  logic        frame_start,
   input  port_cfg_t   cfg,
   output logic        octave_valid,
   output octave_cmd_t octave_cmd,
   output logic        done,
   output logic        busy
);

   typedef enum logic [1:0] {
      seq_idle,
      seq_emit,
      seq_done
   } seq_state_e;

   seq_state_e  state_q;
   port_cfg_t   cfg_q;
   logic [2:0]  octave_q;
   logic [11:0] scale;
   logic        accept;
   logic        last_octave;

   assign accept      = enable && frame_start && (state_q == seq_idle);
   assign last_octave = ((octave_q + 3'd1) == cfg_q.num_octaves);

   // Held for the whole run so later register writes cannot disturb it
   always_ff @(posedge clk) begin
      if (accept) begin
         cfg_q <= cfg;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q  <= seq_idle;
         octave_q <= '0;
      end else begin
         case (state_q)
            seq_idle: begin
               octave_q <= '0;
               if (accept) begin
                  state_q <= (cfg.num_octaves == 3'd0) ? seq_done : seq_emit;
               end
            end
            seq_emit: begin
               if (last_octave) begin
                  state_q <= seq_done;
               end else begin
                  octave_q <= octave_q + 3'd1;
               end
            end
            default: begin
               state_q <= seq_idle; // Done lasts a single cycle
            end
         endcase
      end
   end

   // Largest shift is 63 << 6, which still fits in 12 bits
   assign scale = {6'd0, cfg_q.pattern_scale} << octave_q;

   always_comb begin
      octave_cmd.octave         = octave_q;
      octave_cmd.scale          = scale;
      octave_cmd.lens_invariant = cfg_q.lens_invariant;
   end

   assign octave_valid = (state_q == seq_emit);
   assign done         = (state_q == seq_done);
   assign busy         = (state_q != seq_idle);

   a_no_valid_idle: assert property (@(posedge clk) disable iff (!rst_n)
      octave_valid |-> $past(accept) || $past(octave_valid && !last_octave))
      else $error("[ERROR] octave_valid raised outside a started run");

   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      done |=> !done)
      else $error("[ERROR] done held longer than one cycle");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_feat_front -f feat_front.f &&
./obj_dir/Vtb_feat_front | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run_sim: test run passed" ||
{ echo "run_sim: build or test run failed"; exit 1; }

//--- test/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1; // Released away from the rising edge
   end

endmodule

`default_nettype wire

//--- test/tb_feat_front.sv
`default_nettype none
`timescale 1ns/10ps

module tb_feat_front
   import feat_front_pkg::*;
();

   localparam int word_writes    = 40;
   localparam int subword_writes = 40;
   localparam int runs_per_port  = 6;
   localparam int test_cycles    = 40 + word_writes * 24 + subword_writes * 6
                                   + num_ports * runs_per_port * 16 + 80;
   localparam int limit_ns       = (test_cycles + 200) * 10;

   logic                 clk;
   logic                 rst_n;
   logic                 psel;
   logic                 pwrite;
   access_size_e         psize;
   logic [6:0]           paddr;
   logic [31:0]          pwdata;
   logic [num_ports-1:0] frame_start;
   logic [31:0]          prdata;
   ctrl_regs_t           regs;
   logic [num_ports-1:0] octave_valid;
   logic [num_ports-1:0] done;
   logic [num_ports-1:0] busy;
   octave_cmd_t          octave_cmd0;
   octave_cmd_t          octave_cmd1;
   logic [31:0]          model_regs [0:8];
   logic [31:0]          lfsr_state = 32'hc33790c8;
   int                   checks;
   int                   errors;
   int                   test_errors_start;
   logic [31:0]          r;
   logic [31:0]          d;
   logic [6:0]           a;

   tb_clock_gen i_tb_clock_gen (.clk(clk), .rst_n(rst_n));

   feat_front_top i_feat_front_top (
      .clk(clk), .rst_n(rst_n), .psel(psel), .pwrite(pwrite), .psize(psize),
      .paddr(paddr), .pwdata(pwdata), .frame_start(frame_start), .prdata(prdata),
      .regs(regs), .octave_valid(octave_valid), .octave_cmd0(octave_cmd0),
      .octave_cmd1(octave_cmd1), .done(done), .busy(busy)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] val);
      val = '0;
      repeat (n) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[30:0], lfsr_state[0]};
      end
   endtask

   function automatic logic [31:0] width_mask(input logic [3:0] idx);
      case (idx)
         4'd4:       return 32'h0000_ffff;
         4'd5:       return 32'h00ff_ffff;
         4'd6:       return 32'h0000_00ff;
         4'd7, 4'd8: return 32'h0000_03ff; // Port registers are 10 bits wide
         default:    return 32'hffff_ffff;
      endcase
   endfunction

   function automatic logic [31:0] model_read(input logic [4:0] idx);
      return (idx < 5'd9) ? model_regs[idx[3:0]] : 32'h0;
   endfunction

   task automatic apply_write(input logic [6:0] addr, input access_size_e size,
                              input logic [31:0] data);
      logic [4:0]  idx;
      logic [31:0] mask;
      logic [31:0] lane;
      idx  = addr[6:2];
      mask = (size == size_byte) ? 32'hff : (size == size_half) ? 32'hffff : 32'hffff_ffff;
      lane = (size == size_byte) ? {4{data[7:0]}}
           : (size == size_half) ? {2{data[15:0]}} : data;
      if (idx < 5'd9) begin
         model_regs[idx[3:0]] = ((model_regs[idx[3:0]] & ~mask) | (lane & mask))
                                & width_mask(idx[3:0]);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_regs();
      ctrl_regs_t exp;
      exp = '{model_regs[0], model_regs[1], model_regs[2], model_regs[3],
              model_regs[4][15:0], model_regs[5][23:0], model_regs[6][7:0]};
      checks++;
      assert (regs === exp) else begin
         $display("[ERROR] %0t regs got %h expected %h", $time, regs, exp);
         errors++;
      end
   endtask

   task automatic write_reg(input logic [6:0] addr, input access_size_e size,
                            input logic [31:0] data);
      @(negedge clk);
      psel   = 1'b1;
      pwrite = 1'b1;
      psize  = size;
      paddr  = addr;
      pwdata = data;
      @(negedge clk);
      psel   = 1'b0;
      pwrite = 1'b0;
      apply_write(addr, size, data);
   endtask

   task automatic read_check(input logic [6:0] addr);
      @(negedge clk);
      paddr = addr;
      @(negedge clk);
      check_value("prdata", prdata, model_read(addr[6:2])); // Data from the previous edge
   endtask

   task automatic read_all();
      for (int i = 0; i < 9; i++) read_check({5'(i), 2'b00});
   endtask

   task automatic finish_test(input string name);
      $display("Test %s finished with %0d errors", name, errors - test_errors_start);
      test_errors_start = errors;
   endtask

   task automatic run_port(input logic port, input logic disturb);
      port_cfg_t   cfg;
      octave_cmd_t cmd;
      logic [31:0] val;
      int          n;
      cfg = port_cfg_t'(model_regs[4'(4'd7 + 4'(port))][9:0]);
      n   = int'(cfg.num_octaves);
      @(negedge clk);
      frame_start[port] = 1'b1;
      for (int c = 1; c <= n + 1; c++) begin
         @(negedge clk);
         cmd = port ? octave_cmd1 : octave_cmd0;
         check_value("busy", 32'(busy[port]), 32'd1);
         check_value("done", 32'(done[port]), 32'(c == n + 1));
         check_value("octave_valid", 32'(octave_valid[port]), 32'(c <= n));
         if (c <= n) begin
            check_value("octave", 32'(cmd.octave), 32'(c - 1));
            check_value("scale", 32'(cmd.scale), 32'(cfg.pattern_scale) * (32'd1 << (c - 1)));
            check_value("lens_invariant", 32'(cmd.lens_invariant), 32'(cfg.lens_invariant));
         end
         frame_start[port] = disturb && (c == 1); // A second start while busy is dropped
         if (disturb && c == 2) begin
            rand_bits(32, val);
            psel   = 1'b1;
            pwrite = 1'b1;
            psize  = size_word;
            paddr  = {5'(5'd7 + 5'(port)), 2'b00};
            pwdata = val;
         end
         if (disturb && c == 3) begin
            psel   = 1'b0;
            pwrite = 1'b0;
            apply_write(paddr, size_word, pwdata);
         end
      end
      @(negedge clk);
      check_value("busy", 32'(busy[port]), 32'd0);
      check_value("done", 32'(done[port]), 32'd0);
      check_value("octave_valid", 32'(octave_valid[port]), 32'd0);
   endtask

   initial begin
      psel        = 1'b0;
      pwrite      = 1'b0;
      psize       = size_word;
      paddr       = '0;
      pwdata      = '0;
      frame_start = '0;
      checks            = 0;
      errors            = 0;
      test_errors_start = 0;
      model_regs    = '{default: '0};
      model_regs[4] = 32'(config0_rst);
      model_regs[5] = 32'(config1_rst);
      model_regs[6] = 32'(config2_rst);
      wait (rst_n === 1'b1);

      check_value("octave_valid", 32'(octave_valid), 32'd0);
      check_value("done", 32'(done), 32'd0);
      read_all();
      check_regs();
      finish_test("reset_values");

      for (int i = 0; i < word_writes; i++) begin
         rand_bits(7, r);
         a = r[6:0];
         rand_bits(1, r);
         if (r[0]) a[6:2] = a[6:2] % 5'd9; // Bias half the writes onto mapped words
         rand_bits(32, d);
         write_reg(a, size_word, d);
         read_check(a);
         check_regs();
         if (a[6:2] > 5'd8) read_all();
      end
      finish_test("word_writes");

      for (int i = 0; i < subword_writes; i++) begin
         rand_bits(8, r);
         a = {5'(r % 9), 2'b00};
         rand_bits(1, r);
         rand_bits(32, d);
         write_reg(a, r[0] ? size_half : size_byte, d);
         read_check(a);
         check_regs();
      end
      finish_test("subword_writes");

      for (int p = 0; p < num_ports; p++) begin
         for (int k = 0; k < runs_per_port; k++) begin
            rand_bits(32, d);
            write_reg(7'd0, size_word, d | (32'd1 << p));
            rand_bits(10, d);
            if (k == 0) d[2:0] = 3'd0; // Run with no octaves at all
            write_reg({5'(7 + p), 2'b00}, size_word, d);
            run_port(1'(p), 1'b0);
         end
      end
      finish_test("octave_runs");

      write_reg(7'd0, size_word, 32'h0);
      @(negedge clk);
      frame_start = '1;
      @(negedge clk);
      frame_start = '0;
      repeat (10) begin
         @(negedge clk);
         check_value("busy", 32'(busy), 32'd0);
         check_value("octave_valid", 32'(octave_valid), 32'd0);
         check_value("done", 32'(done), 32'd0);
      end
      write_reg(7'd0, size_word, 32'h3);
      for (int p = 0; p < num_ports; p++) begin
         rand_bits(10, d);
         d[2:0] = 3'd7; // Longest run leaves room for the mid-run write
         write_reg({5'(7 + p), 2'b00}, size_word, d);
         run_port(1'(p), 1'b1);
         read_check({5'(7 + p), 2'b00});
      end
      finish_test("ignored_starts");

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      #(limit_ns);
      $display("Watchdog expired after %0d ns before the tests finished", limit_ns);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire
